/* CpuBackend.f */
+incdir+.
cpu_pkg.sv
RegisterFile.sv
SimpleAlu.sv
LoadStoreUnit.sv
IssueQueue.sv
InstructionIssue.sv
InstructionDecode.sv
CpuBackend.sv
CpuBackend_assert.sv
CpuBackend_checker.sv
CpuBackend_tb.sv

/* CpuBackend.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module CpuBackend import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       awvalid,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    output logic                       awready,
    input  logic                       wvalid,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic                       arvalid,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    output logic                       arready,
    output logic                       rvalid,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready
);

    // Decode to queue
    logic      queueFull;
    logic      queueEmpty;
    logic      pushValid;
    unitSelect pushUnit;
    minorOp    pushOp;
    regAddr    pushDest;
    regAddr    pushSrcA;
    regAddr    pushSrcB;
    dataWord   pushImm;

    // Queue to issue
    logic      headValid;
    unitSelect headUnit;
    minorOp    headOp;
    regAddr    headDest;
    regAddr    headSrcA;
    regAddr    headSrcB;
    dataWord   headImm;
    logic      pop;
    logic      issueBusy;

    // Register file
    regAddr    srcA;
    regAddr    srcB;
    dataWord   dataA;
    dataWord   dataB;
    regAddr    hostReadAddr;
    dataWord   hostReadData;
    logic      regWriteEn;
    regAddr    regWriteAddr;
    dataWord   regWriteData;

    // Functional units
    minorOp                     aluOp;
    dataWord                    aluResult;
    logic                       lsStart;
    logic                       lsWrite;
    logic [`MEM_ADDR_WIDTH-1:0] lsAddr;
    dataWord                    lsData;
    logic                       lsDone;
    dataWord                    lsReadData;

    InstructionDecode u_InstructionDecode (.*);

    IssueQueue u_IssueQueue (
        .full  (queueFull),
        .empty (queueEmpty),
        .*
    );

    InstructionIssue u_InstructionIssue (
        .busy (issueBusy),
        .*
    );

    SimpleAlu u_SimpleAlu (.*);

    LoadStoreUnit u_LoadStoreUnit (.*);

    RegisterFile u_RegisterFile (.*);

endmodule

/* CpuBackend_assert.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module CpuBackend_assert (
    input logic                       clk,
    input logic                       rstN,
    input logic                       awvalid,
    input logic                       bvalid,
    input logic                       bready,
    input logic                       rvalid,
    input logic                       rready,
    input logic                       awready,
    input logic                       queueFull,
    input logic                       lsStart,
    input logic [`MEM_ADDR_WIDTH-1:0] lsAddr,
    input logic                       lsDone
);

    // Responses are held until the host takes them
    bvalidHold: assert property (@(posedge clk) disable iff (!rstN)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalidHold: assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // LSU request and address stay put until completion
    lsRequestStable: assert property (@(posedge clk) disable iff (!rstN)
        lsStart && !lsDone |=> lsStart && $stable(lsAddr))
        else $error("lsStart or lsAddr changed before lsDone");

    // An accepted write gets a response and blocks the next one until then
    writeResponds: assert property (@(posedge clk) disable iff (!rstN)
        awvalid && awready && !queueFull |=> bvalid && !awready)
        else $error("accepted write not followed by a pending response");

endmodule

bind InstructionDecode CpuBackend_assert u_decodeAssert (
    .clk       (clk),
    .rstN      (rstN),
    .awvalid   (awvalid),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .awready   (awready),
    .queueFull (queueFull),
    .lsStart   (1'b0),
    .lsAddr    ('0),
    .lsDone    (1'b0)
);

bind InstructionIssue CpuBackend_assert u_issueAssert (
    .clk       (clk),
    .rstN      (rstN),
    .awvalid   (1'b0),
    .bvalid    (1'b0),
    .bready    (1'b0),
    .rvalid    (1'b0),
    .rready    (1'b0),
    .awready   (1'b0),
    .queueFull (1'b0),
    .lsStart   (lsStart),
    .lsAddr    (lsAddr),
    .lsDone    (lsDone)
);

/* CpuBackend_checker.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module CpuBackend_checker import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       awvalid,
    input  logic                       awready,
    input  logic                       wvalid,
    input  logic                       wready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       bvalid,
    input  logic                       bready,
    input  logic [1:0]                 bresp,
    input  logic                       arvalid,
    input  logic                       arready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                       rvalid,
    input  logic                       rready,
    input  logic [31:0]                rdata,
    input  logic [1:0]                 rresp,
    output int                         errorCount,
    output int                         checkCount
);

    localparam int NUM_REGS  = 2**`REG_ADDR_WIDTH;
    localparam int MEM_WORDS = 2**`MEM_ADDR_WIDTH;

    dataWord     regModel [NUM_REGS];
    dataWord     memModel [MEM_WORDS];
    logic        memWritten [MEM_WORDS];
    logic [31:0] expectedRdata;
    int          errors = 0;
    int          checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // Reference ALU
    function automatic dataWord aluModel(input minorOp op, input dataWord a, input dataWord b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[3:0];
            4'd6:    return a >> b[3:0];
            4'd7:    return (a < b) ? dataWord'(1) : dataWord'(0);
            default: return a;
        endcase
    endfunction

    function automatic logic [31:0] strobed(input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = strb[i] ? data[8*i +: 8] : 8'h00;
        end
        return word;
    endfunction

    // Instructions retire in order, so the model applies them on acceptance
    task automatic applyInstr(input logic [31:0] word);
        regAddr                     dest;
        dataWord                    valA;
        dataWord                    valB;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        dest = word[8 +: `REG_ADDR_WIDTH];
        valA = regModel[word[12 +: `REG_ADDR_WIDTH]];
        valB = regModel[word[16 +: `REG_ADDR_WIDTH]];
        addr = valA[`MEM_ADDR_WIDTH-1:0];
        case (word[5:4])
            2'd0: regModel[dest] = aluModel(word[3:0], valA, valB);
            2'd1: begin
                if (!memWritten[addr]) begin
                    $display("Load from data memory address 0x%h, which was never written", addr);
                    errors++;
                end
                regModel[dest] = memModel[addr];
            end
            2'd2: begin
                memModel[addr]   = valB;
                memWritten[addr] = 1'b1;
            end
            default: regModel[dest] = word[31:16];
        endcase
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regModel[i] = '0;
            end
            for (int i = 0; i < MEM_WORDS; i++) begin
                memWritten[i] = 1'b0;
            end
        end else begin
            if (awvalid && awready && wvalid && wready) begin
                applyInstr(strobed(wdata, wstrb));
            end
            if (bvalid && bready && bresp != 2'b00) begin
                $display("[FAIL] bresp expected 0x0 got 0x%h", bresp);
                errors++;
            end
            // Reads are only accepted once the back end has drained
            if (arvalid && arready) begin
                expectedRdata = 32'(regModel[araddr[2 +: `REG_ADDR_WIDTH]]);
            end
            if (rvalid && rready) begin
                checks++;
                if (rdata !== expectedRdata) begin
                    $display("[FAIL] rdata expected 0x%h got 0x%h", expectedRdata, rdata);
                    errors++;
                end
                if (rresp != 2'b00) begin
                    $display("[FAIL] rresp expected 0x0 got 0x%h", rresp);
                    errors++;
                end
            end
        end
    end

endmodule

/* CpuBackend_tb.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module CpuBackend_tb import cpu_pkg::*; ();

    localparam int TIMEOUT   = 2000;
    localparam int NUM_REGS  = 2**`REG_ADDR_WIDTH;
    localparam int MEM_WORDS = 2**`MEM_ADDR_WIDTH;

    logic                       clk;
    logic                       rstN;
    logic                       awvalid;
    logic [`AXI_ADDR_WIDTH-1:0] awaddr;
    logic                       awready;
    logic                       wvalid;
    logic [31:0]                wdata;
    logic [3:0]                 wstrb;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       bready;
    logic                       arvalid;
    logic [`AXI_ADDR_WIDTH-1:0] araddr;
    logic                       arready;
    logic                       rvalid;
    logic [31:0]                rdata;
    logic [1:0]                 rresp;
    logic                       rready;
    int                         errorCount;
    int                         checkCount;
    int                         bDelayMax;
    int                         rDelayMax;
    int                         errorsBefore;

    CpuBackend u_CpuBackend (.*);

    CpuBackend_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string what);
        $display("Timeout: %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    function automatic int pickDelay(input int maxDelay);
        return (maxDelay > 0) ? int'($urandom_range(maxDelay, 0)) : 0;
    endfunction

    // Random fields, with the unit forced and the spare bits cleared
    function automatic logic [31:0] randomInstr(input logic [1:0] unit);
        logic [31:0] word;
        word = $urandom;
        word[5:4] = unit;
        word[7:6] = 2'b00;
        return word;
    endfunction

    function automatic logic [31:0] makeInstr(input logic [1:0] unit, input regAddr dest,
                                              input regAddr srcA, input dataWord upper);
        return {upper, srcA, dest, 2'b00, unit, 4'h0};
    endfunction

    task automatic writeInstr(input logic [31:0] word);
        int cycles;
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = `AXI_ADDR_WIDTH'($urandom);
        wdata   = word;
        wstrb   = 4'hF;
        cycles  = 0;
        @(posedge clk);
        while (!(awready && wready)) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abortRun("write address and data were never accepted");
            end
            @(posedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (pickDelay(bDelayMax)) @(negedge clk);
        bready = 1'b1;
        cycles = 0;
        @(posedge clk);
        while (!bvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abortRun("no write response arrived");
            end
            @(posedge clk);
        end
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic readReg(input regAddr idx);
        int cycles;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = '0;
        araddr[2 +: `REG_ADDR_WIDTH] = idx;
        cycles  = 0;
        @(posedge clk);
        while (!arready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abortRun("read address was never accepted");
            end
            @(posedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        repeat (pickDelay(rDelayMax)) @(negedge clk);
        rready = 1'b1;
        cycles = 0;
        @(posedge clk);
        while (!rvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abortRun("no read data arrived");
            end
            @(posedge clk);
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic readAllRegs();
        for (int i = 0; i < NUM_REGS; i++) begin
            readReg(regAddr'(i));
        end
    endtask

    task automatic finishTest(input int num, input string name);
        $display("Test %0d %s done, %0d errors", num, name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    task automatic loadImmediates();
        logic [31:0] word;
        for (int i = 0; i < NUM_REGS; i++) begin
            word = randomInstr(UNIT_LOADIMM);
            word[8 +: `REG_ADDR_WIDTH] = regAddr'(i);
            writeInstr(word);
        end
        readAllRegs();
    endtask

    task automatic aluStream();
        logic [31:0] word;
        for (int i = 0; i < 200; i++) begin
            // Walk through every minor op code
            word = randomInstr(UNIT_ALU);
            word[3:0] = 4'(i);
            writeInstr(word);
        end
        readAllRegs();
    endtask

    task automatic memoryAccess();
        dataWord     addrValue;
        logic [31:0] word;
        // Fill every word first, r1 holds the address and r2 the data
        for (int a = 0; a < MEM_WORDS; a++) begin
            addrValue = dataWord'($urandom);
            addrValue[`MEM_ADDR_WIDTH-1:0] = `MEM_ADDR_WIDTH'(a);
            writeInstr(makeInstr(UNIT_LOADIMM, 4'd1, 4'd0, addrValue));
            writeInstr(makeInstr(UNIT_LOADIMM, 4'd2, 4'd0, dataWord'($urandom)));
            writeInstr(makeInstr(UNIT_STORE, 4'd0, 4'd1, 16'h0002));
        end
        for (int i = 0; i < 60; i++) begin
            if ($urandom_range(1, 0) == 0) begin
                writeInstr(randomInstr(UNIT_STORE));
            end else begin
                word = randomInstr(UNIT_LOAD);
                writeInstr(word);
                readReg(word[8 +: `REG_ADDR_WIDTH]);
            end
        end
        readAllRegs();
    endtask

    task automatic backPressure();
        bDelayMax = 8;
        repeat (60) writeInstr(randomInstr(UNIT_ALU));
        bDelayMax = 0;
        readAllRegs();
    endtask

    task automatic mixedStream();
        bDelayMax = 4;
        rDelayMax = 4;
        repeat (300) begin
            if ($urandom_range(3, 0) == 0) begin
                readReg(regAddr'($urandom));
            end else begin
                writeInstr(randomInstr(2'($urandom)));
            end
        end
        readAllRegs();
        bDelayMax = 0;
        rDelayMax = 0;
    endtask

    initial begin
        void'($urandom(57));
        rstN         = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        wstrb        = 4'h0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        bDelayMax    = 0;
        rDelayMax    = 0;
        errorsBefore = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        readAllRegs();
        finishTest(1, "reset values");
        loadImmediates();
        finishTest(2, "load immediate");
        aluStream();
        finishTest(3, "random ALU ops");
        memoryAccess();
        finishTest(4, "stores and loads");
        backPressure();
        finishTest(5, "write back-pressure");
        mixedStream();
        finishTest(6, "mixed stream");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* InstructionDecode.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module InstructionDecode import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    // AXI4-Lite write channel
    input  logic                       awvalid,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    output logic                       awready,
    input  logic                       wvalid,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    // AXI4-Lite read channel
    input  logic                       arvalid,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    output logic                       arready,
    output logic                       rvalid,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready,
    // Issue queue side
    input  logic                       queueFull,
    input  logic                       queueEmpty,
    input  logic                       issueBusy,
    output logic                       pushValid,
    output unitSelect                  pushUnit,
    output minorOp                     pushOp,
    output regAddr                     pushDest,
    output regAddr                     pushSrcA,
    output regAddr                     pushSrcB,
    output dataWord                    pushImm,
    // Host register read port
    output regAddr                     hostReadAddr,
    input  dataWord                    hostReadData
);

    logic [31:0] instrWord;
    logic        readFire;

    // Every write is one instruction, the address does not matter
    assign awready = awvalid && wvalid && !queueFull && !bvalid;
    assign wready  = awready;
    assign bresp   = 2'b00;

    // Lanes without a strobe read as zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            instrWord[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

    assign pushValid = awvalid && awready && wvalid && wready;
    assign pushUnit  = unitSelect'(instrWord[5:4]);
    assign pushOp    = instrWord[3:0];
    assign pushDest  = instrWord[8 +: `REG_ADDR_WIDTH];
    assign pushSrcA  = instrWord[12 +: `REG_ADDR_WIDTH];
    assign pushSrcB  = instrWord[16 +: `REG_ADDR_WIDTH];
    assign pushImm   = instrWord[31:16];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bvalid <= 1'b0;
        end else if (pushValid) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Reads wait until the back end has drained, so they see every accepted write
    assign arready = arvalid && queueEmpty && !issueBusy && !rvalid && !pushValid;
    assign readFire = arvalid && arready;
    assign hostReadAddr = araddr[2 +: `REG_ADDR_WIDTH];
    assign rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rvalid <= 1'b0;
        end else if (readFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (readFire) begin
            rdata <= {{(32-`DATA_WIDTH){1'b0}}, hostReadData};
        end
    end

endmodule

/* InstructionIssue.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module InstructionIssue import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    // Queue head
    input  logic                       headValid,
    input  unitSelect                  headUnit,
    input  minorOp                     headOp,
    input  regAddr                     headDest,
    input  regAddr                     headSrcA,
    input  regAddr                     headSrcB,
    input  dataWord                    headImm,
    output logic                       pop,
    // Operand read
    output regAddr                     srcA,
    output regAddr                     srcB,
    input  dataWord                    dataA,
    input  dataWord                    dataB,
    // ALU
    output minorOp                     aluOp,
    input  dataWord                    aluResult,
    // Load/store handshake
    output logic                       lsStart,
    output logic                       lsWrite,
    output logic [`MEM_ADDR_WIDTH-1:0] lsAddr,
    output dataWord                    lsData,
    input  logic                       lsDone,
    input  dataWord                    lsReadData,
    // Writeback
    output logic                       regWriteEn,
    output regAddr                     regWriteAddr,
    output dataWord                    regWriteData,
    output logic                       busy
);

    issueState  state;
    issueState  nextState;
    logic [3:0] unitEnable;
    wbSource    wbSel;
    logic       stall;

    // One enable per functional unit, only for a valid head
    always_comb begin
        unitEnable = '0;
        if (headValid) begin
            unitEnable[headUnit] = 1'b1;
        end
    end

    assign srcA  = headSrcA;
    assign srcB  = headSrcB;
    assign aluOp = headOp;

    // Request stays up with stable operands for the whole wait
    assign lsStart = (state == ISSUE_MEMWAIT);
    assign lsWrite = unitEnable[UNIT_STORE];
    assign lsAddr  = dataA[`MEM_ADDR_WIDTH-1:0];
    assign lsData  = dataB;

    // Congestion stall while the LSU has not finished
    assign stall = lsStart && !lsDone;

    always_comb begin
        pop       = 1'b0;
        nextState = state;
        case (state)
            ISSUE_IDLE: begin
                if (unitEnable[UNIT_ALU] || unitEnable[UNIT_LOADIMM]) begin
                    pop = 1'b1;
                end else if (unitEnable[UNIT_LOAD] || unitEnable[UNIT_STORE]) begin
                    nextState = ISSUE_MEMWAIT;
                end
            end
            ISSUE_MEMWAIT: begin
                if (!stall) begin
                    pop       = 1'b1;
                    nextState = ISSUE_IDLE;
                end
            end
            default: nextState = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ISSUE_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (headUnit)
            UNIT_LOAD:    wbSel = WB_MEM;
            UNIT_LOADIMM: wbSel = WB_IMM;
            default:      wbSel = WB_ALU;
        endcase
    end

    // Stores retire without touching the register file
    assign regWriteEn   = pop && !unitEnable[UNIT_STORE];
    assign regWriteAddr = headDest;

    always_comb begin
        case (wbSel)
            WB_MEM:  regWriteData = lsReadData;
            WB_IMM:  regWriteData = headImm;
            default: regWriteData = aluResult;
        endcase
    end

    assign busy = lsStart || headValid;

endmodule

/* IssueQueue.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module IssueQueue import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      pushValid,
    input  unitSelect pushUnit,
    input  minorOp    pushOp,
    input  regAddr    pushDest,
    input  regAddr    pushSrcA,
    input  regAddr    pushSrcB,
    input  dataWord   pushImm,
    input  logic      pop,
    output logic      full,
    output logic      empty,
    output logic      headValid,
    output unitSelect headUnit,
    output minorOp    headOp,
    output regAddr    headDest,
    output regAddr    headSrcA,
    output regAddr    headSrcB,
    output dataWord   headImm
);

    localparam int PTR_WIDTH = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(`QUEUE_DEPTH + 1);

    unitSelect unitMem [`QUEUE_DEPTH];
    minorOp    opMem   [`QUEUE_DEPTH];
    regAddr    destMem [`QUEUE_DEPTH];
    regAddr    srcAMem [`QUEUE_DEPTH];
    regAddr    srcBMem [`QUEUE_DEPTH];
    dataWord   immMem  [`QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [CNT_WIDTH-1:0] count;
    logic                 doPush;
    logic                 doPop;

    // Wraps for depths that are not a power of two
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_WIDTH'(`QUEUE_DEPTH));
    assign empty     = (count == '0);
    assign headValid = !empty;
    assign doPush    = pushValid && !full;
    assign doPop     = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            unitMem[wrPtr] <= pushUnit;
            opMem[wrPtr]   <= pushOp;
            destMem[wrPtr] <= pushDest;
            srcAMem[wrPtr] <= pushSrcA;
            srcBMem[wrPtr] <= pushSrcB;
            immMem[wrPtr]  <= pushImm;
        end
    end

    // Head is visible without waiting for a pop
    assign headUnit = unitMem[rdPtr];
    assign headOp   = opMem[rdPtr];
    assign headDest = destMem[rdPtr];
    assign headSrcA = srcAMem[rdPtr];
    assign headSrcB = srcBMem[rdPtr];
    assign headImm  = immMem[rdPtr];

endmodule

/* LoadStoreUnit.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module LoadStoreUnit import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       lsStart,
    input  logic                       lsWrite,
    input  logic [`MEM_ADDR_WIDTH-1:0] lsAddr,
    input  dataWord                    lsData,
    output logic                       lsDone,
    output dataWord                    lsReadData
);

    dataWord    mem [2**`MEM_ADDR_WIDTH];
    logic [7:0] lfsr;
    logic [1:0] waitCnt;
    logic       active;

    // Done in the cycle the counter runs out, 1 to 4 cycles after the request
    assign lsDone     = active && (waitCnt == 2'd0);
    assign lsReadData = mem[lsAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lfsr    <= 8'h01;
            waitCnt <= 2'd0;
            active  <= 1'b0;
        end else begin
            // x^8 + x^6 + x^5 + x^4 + 1
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (lsDone) begin
                active <= 1'b0;
            end else if (active) begin
                waitCnt <= waitCnt - 2'd1;
            end else if (lsStart) begin
                active  <= 1'b1;
                waitCnt <= lfsr[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsDone && lsWrite) begin
            mem[lsAddr] <= lsData;
        end
    end

endmodule

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module CpuBackend_tb -f CpuBackend.f
	./obj_dir/VCpuBackend_tb > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log
	cat sim.log
	! grep -qF "*** TEST FAILED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* RegisterFile.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module RegisterFile import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddr  srcA,
    input  regAddr  srcB,
    input  regAddr  hostReadAddr,
    input  logic    regWriteEn,
    input  regAddr  regWriteAddr,
    input  dataWord regWriteData,
    output dataWord dataA,
    output dataWord dataB,
    output dataWord hostReadData
);

    dataWord regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteEn) begin
            regs[regWriteAddr] <= regWriteData;
        end
    end

    // Issue operands and host port
    assign dataA        = regs[srcA];
    assign dataB        = regs[srcB];
    assign hostReadData = regs[hostReadAddr];

endmodule

/* SimpleAlu.sv */
`timescale 1ns/100ps

module SimpleAlu import cpu_pkg::*; (
    input  minorOp  aluOp,
    input  dataWord dataA,
    input  dataWord dataB,
    output dataWord aluResult
);

    logic [3:0] shiftAmount;

    // Shifts use only the low nibble of B
    assign shiftAmount = dataB[3:0];

    always_comb begin
        case (aluOp)
            4'd0:    aluResult = dataA + dataB;
            4'd1:    aluResult = dataA - dataB;
            4'd2:    aluResult = dataA & dataB;
            4'd3:    aluResult = dataA | dataB;
            4'd4:    aluResult = dataA ^ dataB;
            4'd5:    aluResult = dataA << shiftAmount;
            4'd6:    aluResult = dataA >> shiftAmount;
            // Unsigned compare, result is 0 or 1
            4'd7:    aluResult = dataWord'(dataA < dataB);
            default: aluResult = dataA;
        endcase
    end

endmodule

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Register and memory word width
`define DATA_WIDTH 16

// 16 architectural registers
`define REG_ADDR_WIDTH 4

// Issue queue entries
`define QUEUE_DEPTH 4

// 64 words of data memory
`define MEM_ADDR_WIDTH 6

`define AXI_ADDR_WIDTH 8

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

// Instruction word written by the host
//   [3:0]   minor op
//   [5:4]   unit
//   [11:8]  destination register
//   [15:12] source A
//   [19:16] source B
//   [31:16] immediate, load-immediate only
// Load reads memory at the low address bits of register A
// Store writes register B to the same address, no writeback
package cpu_pkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

    // 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 sltu, 8-15 pass A
    typedef logic [3:0] minorOp;

    typedef enum logic [1:0] {
        UNIT_ALU     = 2'd0,
        UNIT_LOAD    = 2'd1,
        UNIT_STORE   = 2'd2,
        UNIT_LOADIMM = 2'd3
    } unitSelect;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IMM = 2'd2
    } wbSource;

    typedef enum logic {
        ISSUE_IDLE    = 1'b0,
        ISSUE_MEMWAIT = 1'b1
    } issueState;

endpackage
